/* compile.f */
+incdir+hw
hw/msx_pkg.sv
hw/msx_io_bus.sv
hw/msx_ppi.sv
hw/msx_primary_slot.sv
hw/msx_wait_gen.sv
hw/msx_psg_strobe.sv
hw/msx_audio_mix.sv
hw/msx_core.sv
tests/msx_core_tb.sv

/* hw/msx_audio_mix.sv */
`timescale 1ns/1ps
`include "msx_settings.svh"

module msx_audio_mix (
   input  logic                clk21m,
   input  logic                exwait_n,
   input  msx_pkg::psg_sound_t psg_sound_i,
   input  logic                keybeep_i,
   input  logic                cas_audio_i,
   input  logic                cas_motor_i,
   input  msx_pkg::audio_t     cart_sound_i,
   output msx_pkg::audio_t     audio_o
);

   msx_pkg::psg_sound_t beep_w;
   msx_pkg::psg_sound_t cas_w;
   logic [10:0]         psg_sum;
   logic [16:0]         mix;
   msx_pkg::audio_t     compr;

   // tape is only heard with the motor relay off
   assign beep_w  = msx_pkg::psg_sound_t'(keybeep_i) << `MSX_BEEP_SHIFT;
   assign cas_w   = msx_pkg::psg_sound_t'(cas_audio_i & ~cas_motor_i) << `MSX_CAS_SHIFT;
   // one extra bit so a loud psg plus click does not wrap
   assign psg_sum = psg_sound_i + beep_w + cas_w;

   // psg scaled up, cartridge sample sign extended
   assign mix = {2'b00, psg_sum, 4'b0000} + {cart_sound_i[15], cart_sound_i};

   always_comb begin
      case (mix[16:14])
         3'b000:                 compr = {1'b0, mix[13:0], 1'b0};
         3'b111:                 compr = {1'b1, mix[13:0], 1'b0};
         3'b001, 3'b010, 3'b011: compr = 16'sh7FFF;
         default:                compr = 16'sh8000;
      endcase
   end

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         audio_o <= '0;
      end else begin
         audio_o <= compr;
      end
   end

endmodule

/* hw/msx_core.sv */
`timescale 1ns/1ps

module msx_core (
   input  logic                clk21m,
   input  logic                exwait_n,
   input  logic                ce_3m58_p_i,
   input  msx_pkg::cpu_bus_t   cpu_i,
   input  msx_pkg::cpu_data_t  vdp_data_i,
   input  msx_pkg::cpu_data_t  psg_data_i,
   input  msx_pkg::cpu_data_t  slot_data_i,
   input  msx_pkg::cpu_data_t  kb_data_i,
   input  msx_pkg::psg_sound_t psg_sound_i,
   input  msx_pkg::audio_t     cart_sound_i,
   input  logic                cas_audio_i,
   output msx_pkg::cpu_data_t  cpu_data_o,
   output logic                wait_n_o,
   output logic                vdp_sel_o,
   output logic                psg_bdir_o,
   output logic                psg_bc1_o,
   output msx_pkg::slot_t      slot_o,
   output logic [3:0]          kb_row_o,
   output logic                cas_motor_o,
   output msx_pkg::audio_t     audio_o
);

   msx_pkg::io_sel_t   sel;
   msx_pkg::cpu_data_t ppi_data;
   msx_pkg::cpu_data_t port_a;
   msx_pkg::cpu_data_t port_c;
   logic               keybeep;

   // port decode and read-back mux
   msx_io_bus u_io_bus (
      .cpu_i       (cpu_i),
      .vdp_data_i  (vdp_data_i),
      .psg_data_i  (psg_data_i),
      .ppi_data_i  (ppi_data),
      .slot_data_i (slot_data_i),
      .sel_o       (sel),
      .cpu_data_o  (cpu_data_o)
   );

   msx_ppi u_ppi (
      .clk21m    (clk21m),
      .exwait_n  (exwait_n),
      .cpu_i     (cpu_i),
      .cs_i      (sel.ppi),
      .kb_data_i (kb_data_i),
      .port_a_o  (port_a),
      .port_c_o  (port_c),
      .data_o    (ppi_data)
   );

   // port c: row select low nibble, motor on bit 4, click on bit 7
   assign kb_row_o    = port_c[3:0];
   assign cas_motor_o = port_c[4];
   assign keybeep     = port_c[7];
   assign vdp_sel_o   = sel.vdp;

   msx_primary_slot u_primary_slot (
      .clk21m   (clk21m),
      .exwait_n (exwait_n),
      .cs_i     (sel.ppi),
      .addr_i   (cpu_i.addr),
      .port_a_i (port_a),
      .slot_o   (slot_o)
   );

   msx_wait_gen u_wait_gen (
      .clk21m      (clk21m),
      .exwait_n    (exwait_n),
      .ce_3m58_p_i (ce_3m58_p_i),
      .m1_n_i      (cpu_i.m1_n),
      .wait_n_o    (wait_n_o)
   );

   msx_psg_strobe u_psg_strobe (
      .clk21m      (clk21m),
      .exwait_n    (exwait_n),
      .ce_3m58_p_i (ce_3m58_p_i),
      .cs_i        (sel.psg),
      .addr_i      (cpu_i.addr[1:0]),
      .bdir_o      (psg_bdir_o),
      .bc1_o       (psg_bc1_o)
   );

   msx_audio_mix u_audio_mix (
      .clk21m       (clk21m),
      .exwait_n     (exwait_n),
      .psg_sound_i  (psg_sound_i),
      .keybeep_i    (keybeep),
      .cas_audio_i  (cas_audio_i),
      .cas_motor_i  (cas_motor_o),
      .cart_sound_i (cart_sound_i),
      .audio_o      (audio_o)
   );

endmodule

/* hw/msx_io_bus.sv */
`timescale 1ns/1ps
`include "msx_settings.svh"

module msx_io_bus (
   input  msx_pkg::cpu_bus_t  cpu_i,
   input  msx_pkg::cpu_data_t vdp_data_i,
   input  msx_pkg::cpu_data_t psg_data_i,
   input  msx_pkg::cpu_data_t ppi_data_i,
   input  msx_pkg::cpu_data_t slot_data_i,
   output msx_pkg::io_sel_t   sel_o,
   output msx_pkg::cpu_data_t cpu_data_o
);

   logic io_cycle;
   logic [4:0] port_hi;

   // interrupt acknowledge also drives iorq low, keep it out
   assign io_cycle = ~cpu_i.iorq_n & cpu_i.m1_n;
   assign port_hi  = cpu_i.addr[7:3];

   assign sel_o.vdp = io_cycle & (port_hi == `MSX_PORT_VDP);
   assign sel_o.psg = io_cycle & (port_hi == `MSX_PORT_PSG);
   assign sel_o.ppi = io_cycle & (port_hi == `MSX_PORT_PPI);

   // read data back to the cpu
   always_comb begin
      if (cpu_i.rd_n) begin
         // idle bus floats high
         cpu_data_o = 8'hFF;
      end else if (sel_o.vdp) begin
         cpu_data_o = vdp_data_i;
      end else if (sel_o.psg) begin
         cpu_data_o = psg_data_i;
      end else if (sel_o.ppi) begin
         cpu_data_o = ppi_data_i;
      end else begin
         // memory and anything undecoded
         cpu_data_o = slot_data_i;
      end
   end

endmodule

/* hw/msx_pkg.sv */
package msx_pkg;

   // cpu address and data
   typedef logic [15:0] cpu_addr_t;
   typedef logic [7:0]  cpu_data_t;

   // primary slot number, one per 16 KB page
   typedef logic [1:0] slot_t;

   // sound chip channel mix, unsigned
   typedef logic [9:0] psg_sound_t;

   // final sample, two's complement
   typedef logic signed [15:0] audio_t;

   // z80 bus as seen by the core, strobes active low
   typedef struct packed {
      cpu_addr_t addr;
      cpu_data_t data;
      logic      mreq_n;
      logic      iorq_n;
      logic      rd_n;
      logic      wr_n;
      logic      m1_n;
   } cpu_bus_t;

   // decoded i/o selects, active high
   typedef struct packed {
      logic psg;
      logic ppi;
      logic vdp;
   } io_sel_t;

endpackage

/* hw/msx_ppi.sv */
`timescale 1ns/1ps

module msx_ppi (
   input  logic               clk21m,
   input  logic               exwait_n,
   input  msx_pkg::cpu_bus_t  cpu_i,
   input  logic               cs_i,
   input  msx_pkg::cpu_data_t kb_data_i,
   output msx_pkg::cpu_data_t port_a_o,
   output msx_pkg::cpu_data_t port_c_o,
   output msx_pkg::cpu_data_t data_o
);

   msx_pkg::cpu_data_t port_a_q;
   msx_pkg::cpu_data_t port_c_q;
   logic               wr_n_q;
   logic               wr_stb;
   logic [1:0]         offset;

   assign offset = cpu_i.addr[1:0];

   // one write per bus cycle, on the falling wr_n
   assign wr_stb = cs_i & ~cpu_i.wr_n & wr_n_q;

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         wr_n_q <= 1'b1;
      end else begin
         wr_n_q <= cpu_i.wr_n;
      end
   end

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         port_a_q <= '0;
         port_c_q <= '0;
      end else if (wr_stb) begin
         case (offset)
            2'd0: port_a_q <= cpu_i.data;
            2'd2: port_c_q <= cpu_i.data;
            2'd3: begin
               if (cpu_i.data[7]) begin
                  // mode word, outputs return to zero
                  port_a_q <= '0;
                  port_c_q <= '0;
               end else begin
                  // port c bit set/reset
                  port_c_q[cpu_i.data[3:1]] <= cpu_i.data[0];
               end
            end
            default: ;
         endcase
      end
   end

   // port b is the keyboard column input
   always_comb begin
      case (offset)
         2'd0:    data_o = port_a_q;
         2'd1:    data_o = kb_data_i;
         2'd2:    data_o = port_c_q;
         default: data_o = 8'hFF;
      endcase
   end

   assign port_a_o = port_a_q;
   assign port_c_o = port_c_q;

endmodule

/* hw/msx_primary_slot.sv */
`timescale 1ns/1ps

module msx_primary_slot (
   input  logic               clk21m,
   input  logic               exwait_n,
   input  logic               cs_i,
   input  msx_pkg::cpu_addr_t addr_i,
   input  msx_pkg::cpu_data_t port_a_i,
   output msx_pkg::slot_t     slot_o
);

   logic slot_valid;
   logic [1:0] page;

   // boot rom sits in slot 0 until the bios touches the ppi
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         slot_valid <= 1'b0;
      end else if (cs_i) begin
         slot_valid <= 1'b1;
      end
   end

   assign page = addr_i[15:14];

   // two bits of port a per 16 KB page
   always_comb begin
      if (!slot_valid) begin
         slot_o = '0;
      end else begin
         slot_o = port_a_i[{page, 1'b0} +: 2];
      end
   end

endmodule

/* hw/msx_psg_strobe.sv */
`timescale 1ns/1ps

module msx_psg_strobe (
   input  logic       clk21m,
   input  logic       exwait_n,
   input  logic       ce_3m58_p_i,
   input  logic       cs_i,
   input  logic [1:0] addr_i,
   output logic       bdir_o,
   output logic       bc1_o
);

   logic stage1_q;
   logic stage2_q;
   logic strobe_en;

   // counts two cpu clocks into the select
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         stage1_q <= 1'b0;
         stage2_q <= 1'b0;
      end else if (!cs_i) begin
         stage1_q <= 1'b0;
         stage2_q <= 1'b0;
      end else if (ce_3m58_p_i) begin
         stage1_q <= 1'b1;
         stage2_q <= stage1_q;
      end
   end

   // drop out on the cpu clock strobe and as soon as the select goes
   assign strobe_en = stage2_q & ~ce_3m58_p_i & cs_i;

   // a1=0 latch/write, a0=0 address select
   assign bdir_o = strobe_en & ~addr_i[1];
   assign bc1_o  = strobe_en & ~addr_i[0];

endmodule

/* hw/msx_settings.svh */
`ifndef MSX_SETTINGS_SVH
`define MSX_SETTINGS_SVH

// upper five address bits of each i/o block

// video chip, ports 0x98-0x9f
`define MSX_PORT_VDP 5'b10011

// sound generator, ports 0xa0-0xa7
`define MSX_PORT_PSG 5'b10100

// peripheral interface, ports 0xa8-0xab
`define MSX_PORT_PPI 5'b10101

// bit positions where key click and tape input join the sound sum
`define MSX_BEEP_SHIFT 5
`define MSX_CAS_SHIFT 4

`endif

/* hw/msx_wait_gen.sv */
`timescale 1ns/1ps

module msx_wait_gen (
   input  logic clk21m,
   input  logic exwait_n,
   input  logic ce_3m58_p_i,
   input  logic m1_n_i,
   output logic wait_n_o
);

   logic wait_q;
   logic wait_dly_q;

   // pulls wait low on an opcode fetch, released by the delayed copy
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         wait_q <= 1'b0;
      end else if (!wait_dly_q) begin
         wait_q <= 1'b1;
      end else if (ce_3m58_p_i) begin
         wait_q <= m1_n_i;
      end
   end

   // wait level one cpu clock later
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         wait_dly_q <= 1'b1;
      end else if (ce_3m58_p_i) begin
         wait_dly_q <= wait_q;
      end
   end

   assign wait_n_o = wait_q;

endmodule

/* tests/msx_core_tb.sv */
`timescale 1ns/1ps
`include "msx_settings.svh"

module msx_core_tb;

   localparam int NB = 22;
   localparam int NA = 7;

   typedef enum logic [1:0] {IO_WR, IO_RD, MEM_RD} op_e;
   typedef struct packed {
      op_e         op;
      logic [15:0] addr;
      logic [7:0]  data;
   } bus_row_t;
   // psg sound, click, tape in, motor, cartridge sample, expected output
   typedef struct packed {
      logic [9:0]  psg;
      logic        click;
      logic        cas;
      logic        motor;
      logic [15:0] cart;
      logic [15:0] exp;
   } mix_row_t;

   logic clk21m = 1'b0, exwait_n = 1'b0, ce_3m58_p = 1'b0, cas_audio = 1'b0;
   logic [2:0] ce_cnt = '0;
   msx_pkg::cpu_bus_t cpu;
   msx_pkg::cpu_data_t vdp_data, psg_data, slot_data, kb_data, cpu_data_o, got_data;
   msx_pkg::psg_sound_t psg_sound;
   msx_pkg::audio_t cart_sound, audio_o;
   msx_pkg::slot_t slot_o, got_slot;
   logic wait_n_o, vdp_sel_o, psg_bdir_o, psg_bc1_o, cas_motor_o, seen_vsel, seen_bdir, seen_bc1;
   logic [3:0] kb_row_o;
   logic [7:0] mdl_a = '0, mdl_c = '0;
   logic mdl_valid = 1'b0;
   bus_row_t bus_tab [NB];
   mix_row_t mix_tab [NA];
   int errors = 0, tests = 0, failed = 0;

   msx_core dut (
      .clk21m(clk21m), .exwait_n(exwait_n), .ce_3m58_p_i(ce_3m58_p), .cpu_i(cpu),
      .vdp_data_i(vdp_data), .psg_data_i(psg_data), .slot_data_i(slot_data),
      .kb_data_i(kb_data), .psg_sound_i(psg_sound), .cart_sound_i(cart_sound),
      .cas_audio_i(cas_audio), .cpu_data_o(cpu_data_o), .wait_n_o(wait_n_o),
      .vdp_sel_o(vdp_sel_o), .psg_bdir_o(psg_bdir_o), .psg_bc1_o(psg_bc1_o), .slot_o(slot_o),
      .kb_row_o(kb_row_o), .cas_motor_o(cas_motor_o), .audio_o(audio_o)
   );

   always #5 clk21m = ~clk21m;

   // 3.58 MHz enable, one clk21m cycle in six
   always @(posedge clk21m) begin
      ce_cnt <= (ce_cnt == 3'd5) ? 3'd0 : ce_cnt + 3'd1;
      ce_3m58_p <= (ce_cnt == 3'd5);
   end

   initial begin
      #((NB + NA) * 200 + 2000);
      $display("watchdog expired before all tests finished");
      $display("test failed");
      $finish;
   end

   task automatic mismatch(input string name, input logic [15:0] got, input logic [15:0] exp);
      $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
   endtask

   task automatic finish_test(input string what, input int e0);
      tests++;
      if (errors != e0) failed++;
      $display("test %0d %s: %s", tests, what, (errors == e0) ? "ok" : "FAILED");
   endtask

   // one bus cycle, 16 clocks long, outputs sampled on falling edges
   task automatic bus_cycle(input bus_row_t r);
      seen_vsel = 1'b0;
      seen_bdir = 1'b0;
      seen_bc1  = 1'b0;
      @(posedge clk21m);
      {vdp_data, psg_data} <= {8'($urandom), 8'($urandom)};
      {slot_data, kb_data} <= {8'($urandom), 8'($urandom)};
      cpu.addr   <= r.addr;
      cpu.data   <= r.data;
      cpu.mreq_n <= (r.op != MEM_RD);
      cpu.iorq_n <= (r.op == MEM_RD);
      cpu.rd_n   <= (r.op == IO_WR);
      cpu.wr_n   <= (r.op != IO_WR);
      repeat (16) begin
         @(negedge clk21m);
         seen_vsel |= vdp_sel_o;
         seen_bdir |= psg_bdir_o;
         seen_bc1  |= psg_bc1_o;
      end
      got_data = cpu_data_o;
      got_slot = slot_o;
      @(posedge clk21m);
      {cpu.mreq_n, cpu.iorq_n, cpu.rd_n, cpu.wr_n} <= 4'b1111;
      @(negedge clk21m);
      // ppi register model
      if (r.op != MEM_RD && r.addr[7:3] == `MSX_PORT_PPI) mdl_valid = 1'b1;
      if (r.op == IO_WR && r.addr[7:3] == `MSX_PORT_PPI) begin
         if (r.addr[1:0] == 2'd0) mdl_a = r.data;
         if (r.addr[1:0] == 2'd2) mdl_c = r.data;
         if (r.addr[1:0] == 2'd3 && r.data[7]) {mdl_a, mdl_c} = '0;
         if (r.addr[1:0] == 2'd3 && !r.data[7]) mdl_c[r.data[3:1]] = r.data[0];
      end
   endtask

   function automatic logic [7:0] expect_read(input bus_row_t r);
      if (r.op == MEM_RD) return slot_data;
      if (r.addr[7:3] == `MSX_PORT_VDP) return vdp_data;
      if (r.addr[7:3] == `MSX_PORT_PSG) return psg_data;
      if (r.addr[7:3] != `MSX_PORT_PPI) return slot_data;
      case (r.addr[1:0])
         2'd0:    return mdl_a;
         2'd1:    return kb_data;
         2'd2:    return mdl_c;
         default: return 8'hFF;
      endcase
   endfunction

   task automatic check_bus_row(input bus_row_t r);
      logic io;
      logic psg;
      logic vsel;
      logic [1:0] exp_slot;
      io = (r.op != MEM_RD);
      psg = io && (r.addr[7:3] == `MSX_PORT_PSG);
      vsel = io && (r.addr[7:3] == `MSX_PORT_VDP);
      exp_slot = mdl_valid ? 2'(mdl_a >> (2 * r.addr[15:14])) : 2'b00;
      if (r.op != IO_WR && got_data !== expect_read(r))
         mismatch("cpu_data_o", got_data, expect_read(r));
      if (r.op == MEM_RD && got_slot !== exp_slot) mismatch("slot_o", got_slot, exp_slot);
      if (seen_vsel !== vsel) mismatch("vdp_sel_o", seen_vsel, vsel);
      if (seen_bdir !== (psg && !r.addr[1])) mismatch("psg_bdir_o", seen_bdir, psg && !r.addr[1]);
      if (seen_bc1 !== (psg && !r.addr[0])) mismatch("psg_bc1_o", seen_bc1, psg && !r.addr[0]);
      // bus idle again
      if (cpu_data_o !== 8'hFF) mismatch("cpu_data_o", cpu_data_o, 8'hFF);
      if ({psg_bdir_o, psg_bc1_o} !== 2'b00)
         mismatch("psg_bdir_o/psg_bc1_o", {psg_bdir_o, psg_bc1_o}, 0);
      if (kb_row_o !== mdl_c[3:0]) mismatch("kb_row_o", kb_row_o, mdl_c[3:0]);
      if (cas_motor_o !== mdl_c[4]) mismatch("cas_motor_o", cas_motor_o, mdl_c[4]);
   endtask

   task automatic m1_fetch();
      int t;
      @(posedge clk21m);
      cpu.addr <= 16'h0100;
      {cpu.mreq_n, cpu.rd_n, cpu.m1_n} <= 3'b000;
      t = 0;
      do begin
         @(negedge clk21m);
         t++;
      end while (wait_n_o === 1'b1 && t < 40);
      if (wait_n_o !== 1'b0) begin
         $display("wait_n_o never fell during the M1 fetch");
         errors++;
      end
      t = 0;
      do begin
         @(negedge clk21m);
         t++;
      end while (wait_n_o === 1'b0 && t < 40);
      if (wait_n_o !== 1'b1) begin
         $display("wait_n_o stuck low while m1_n was low");
         errors++;
      end
      @(posedge clk21m);
      {cpu.mreq_n, cpu.rd_n, cpu.m1_n} <= 3'b111;
      t = 0;
      repeat (30) begin
         @(negedge clk21m);
         if (wait_n_o !== 1'b1) t++;
      end
      if (t != 0) begin
         $display("wait_n_o fell with m1_n high");
         errors++;
      end
   endtask

   initial begin
      int e0;
      int seed;
      seed = $urandom(32'h2c4a_3be8);
      cpu = {16'h0000, 8'h00, 5'b11111};
      {vdp_data, psg_data, slot_data, kb_data} = '0;
      psg_sound = '0;
      cart_sound = '0;
      bus_tab[0] = {MEM_RD, 16'hC000, 8'h00};
      bus_tab[1] = {IO_WR, 16'h00A8, 8'hE4};
      bus_tab[2] = {IO_WR, 16'h00AA, 8'h53};
      bus_tab[3] = {IO_WR, 16'h00AB, 8'h0F};
      bus_tab[4] = {IO_WR, 16'h00AB, 8'h08};
      bus_tab[5] = {IO_RD, 16'h00A8, 8'h00};
      bus_tab[6] = {IO_RD, 16'h00A9, 8'h00};
      bus_tab[7] = {IO_RD, 16'h00AA, 8'h00};
      bus_tab[8] = {MEM_RD, 16'h0000, 8'h00};
      bus_tab[9] = {MEM_RD, 16'h4000, 8'h00};
      bus_tab[10] = {MEM_RD, 16'h8000, 8'h00};
      bus_tab[11] = {MEM_RD, 16'hC000, 8'h00};
      bus_tab[12] = {IO_RD, 16'h0098, 8'h00};
      bus_tab[13] = {IO_RD, 16'h00A2, 8'h00};
      bus_tab[14] = {MEM_RD, 16'h1234, 8'h00};
      bus_tab[15] = {IO_WR, 16'h00A0, 8'h3C};
      bus_tab[16] = {IO_WR, 16'h009A, 8'h77};
      bus_tab[17] = {IO_WR, 16'h00A8, 8'h1B};
      bus_tab[18] = {MEM_RD, 16'h7FFF, 8'h00};
      bus_tab[19] = {MEM_RD, 16'hBFFF, 8'h00};
      bus_tab[20] = {IO_WR, 16'h00AB, 8'h80};
      bus_tab[21] = {IO_RD, 16'h00AA, 8'h00};
      // 4 and 6 saturate positive, 5 negative
      mix_tab[0] = {10'h100, 3'b000, 16'h0000, 16'h2000};
      mix_tab[1] = {10'h010, 3'b110, 16'hFF00, 16'h0600};
      mix_tab[2] = {10'h020, 3'b000, 16'hF000, 16'hE400};
      mix_tab[3] = {10'h000, 3'b010, 16'h0000, 16'h0200};
      mix_tab[4] = {10'h3C0, 3'b111, 16'h7000, 16'h7FFF};
      mix_tab[5] = {10'h000, 3'b000, 16'h8000, 16'h8000};
      mix_tab[6] = {10'h3F0, 3'b110, 16'h0000, 16'h7FFF};
      repeat (5) @(posedge clk21m);
      @(negedge clk21m);
      e0 = errors;
      if ({wait_n_o, psg_bdir_o, psg_bc1_o, slot_o, kb_row_o, cas_motor_o} !== '0)
         mismatch("outputs in reset",
                  {wait_n_o, psg_bdir_o, psg_bc1_o, slot_o, kb_row_o, cas_motor_o}, 0);
      if (audio_o !== 16'sh0000) mismatch("audio_o", audio_o, 16'h0000);
      finish_test("reset state", e0);
      repeat (5) @(posedge clk21m);
      exwait_n <= 1'b1;
      repeat (4) @(posedge clk21m);
      for (int n = 0; n < NB; n++) begin
         e0 = errors;
         bus_cycle(bus_tab[n]);
         check_bus_row(bus_tab[n]);
         finish_test($sformatf("bus op %0d addr %h", bus_tab[n].op, bus_tab[n].addr), e0);
      end
      e0 = errors;
      m1_fetch();
      finish_test("M1 wait state", e0);
      for (int n = 0; n < NA; n++) begin
         e0 = errors;
         // click on port c bit 7, motor on bit 4
         bus_cycle({IO_WR, 16'h00AA, mix_tab[n].click, 2'b00, mix_tab[n].motor, 4'h0});
         @(posedge clk21m);
         psg_sound  <= mix_tab[n].psg;
         cart_sound <= mix_tab[n].cart;
         cas_audio  <= mix_tab[n].cas;
         @(posedge clk21m);
         @(negedge clk21m);
         if (audio_o !== mix_tab[n].exp) mismatch("audio_o", audio_o, mix_tab[n].exp);
         finish_test($sformatf("audio mix %0d", n), e0);
      end
      $display("tests %0d failed %0d errors %0d", tests, failed, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule
